// File: list.f
uart_pkg.sv
uart_baud_gen.sv
uart_rx_des.sv
uart_rx_check.sv
uart_tx_ser.sv
uart_top.sv
tb_clk_gen.sv
uart_sva.sv
uart_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module uart_tb -f list.f -o uart_sim
	./obj_dir/uart_sim

clean:
	rm -rf obj_dir

// File: uart_tb.sv
module uart_tb;

   localparam int WORD_WIDTH    = 8;
   localparam int OVERSAMPLING  = 8;
   localparam int CLKS_PER_TICK = 2;
   localparam int BIT_CLKS      = OVERSAMPLING * CLKS_PER_TICK;
   localparam logic [31:0] SEED = 32'hf92f_7083;
   localparam int N_LOOP = 12; // per loopback phase
   localparam int N_PAR  = 6;
   localparam int N_STOP = 4;
   localparam int N_DROP = 6;
   localparam int TOTAL_FRAMES = 2 * N_LOOP + N_PAR + N_STOP + N_DROP;
   localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 12 * BIT_CLKS * 2;

   logic                  clk;
   logic                  rst_n;
   logic                  rxd;
   logic                  parity_en;
   logic                  tx_start;
   logic [WORD_WIDTH-1:0] tx_data;
   logic                  txd;
   logic                  tx_busy;
   logic [WORD_WIDTH-1:0] rx_data;
   logic                  rx_valid;
   logic                  rx_parity_err;
   logic                  rx_frame_err;
   logic                  rx_active;

   logic                  loop_sel;
   logic                  bang_line;
   logic [31:0]           lfsr;
   logic [31:0]           r;
   logic [9:0]            exp_q[$]; // {frame_err, parity_err, data}
   logic [9:0]            exp_entry;
   logic [WORD_WIDTH-1:0] last_data;
   int                    n_accepted;
   int                    n_received;

   tb_clk_gen #(.PERIOD(4)) clk_gen_inst (.clk(clk));

   uart_top #(
      .WORD_WIDTH    (WORD_WIDTH),
      .OVERSAMPLING  (OVERSAMPLING),
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) uart_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .rxd           (rxd),
      .parity_en     (parity_en),
      .tx_start      (tx_start),
      .tx_data       (tx_data),
      .txd           (txd),
      .tx_busy       (tx_busy),
      .rx_data       (rx_data),
      .rx_valid      (rx_valid),
      .rx_parity_err (rx_parity_err),
      .rx_frame_err  (rx_frame_err),
      .rx_active     (rx_active)
   );

   assign rxd = loop_sel ? txd : bang_line; // loopback or built frames

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic wait_idle();
      do @(negedge clk); while (tx_busy || rx_active);
   endtask

   task automatic send_word(input logic [WORD_WIDTH-1:0] w);
      do @(negedge clk); while (tx_busy);
      @(posedge clk);
      tx_start <= 1'b1;
      tx_data  <= w;
      @(posedge clk);
      tx_start <= 1'b0;
      exp_q.push_back({1'b0, 1'b0, w});
      n_accepted++;
   endtask

   task automatic drive_bit(input logic b, input int n);
      @(posedge clk);
      bang_line <= b;
      repeat (n - 1) @(posedge clk);
   endtask

   task automatic send_frame(input logic [WORD_WIDTH-1:0] w, input logic flip_par,
                             input logic stop_val);
      drive_bit(1'b0, BIT_CLKS);
      for (int i = 0; i < WORD_WIDTH; i++)
         drive_bit(w[i], BIT_CLKS);
      if (parity_en)
         drive_bit((^w) ^ flip_par, BIT_CLKS);
      if (stop_val)
         drive_bit(1'b1, BIT_CLKS);
      else
         drive_bit(1'b0, BIT_CLKS * 3 / 4); // high again before the next start check
      drive_bit(1'b1, 2 * BIT_CLKS);
   endtask

   // receive side model
   always @(negedge clk) begin
      if (rst_n && (rx_valid || rx_frame_err)) begin
         if (rx_valid)
            n_received++;
         if (exp_q.size() == 0) begin
            fail_run("receiver reported a frame that nobody sent");
         end else begin
            exp_entry = exp_q.pop_front();
            check_value("rx_frame_err", 32'(rx_frame_err), 32'(exp_entry[9]));
            check_value("rx_valid", 32'(rx_valid), 32'(!exp_entry[9]));
            check_value("rx_parity_err", 32'(rx_parity_err), 32'(exp_entry[8]));
            if (!exp_entry[9])
               last_data = exp_entry[7:0];
            check_value("rx_data", 32'(rx_data), 32'(last_data)); // held on frame errors
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      fail_run("watchdog expired before all frames were received");
   end

   initial begin
      lfsr       = SEED;
      last_data  = '0;
      n_accepted = 0;
      n_received = 0;
      rst_n     <= 1'b0;
      parity_en <= 1'b0;
      tx_start  <= 1'b0;
      tx_data   <= '0;
      loop_sel  <= 1'b1;
      bang_line <= 1'b1;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      @(negedge clk);
      check_value("txd", 32'(txd), 32'd1);
      check_value("tx_busy", 32'(tx_busy), 32'd0);
      check_value("rx_valid", 32'(rx_valid), 32'd0);
      check_value("rx_parity_err", 32'(rx_parity_err), 32'd0);
      check_value("rx_frame_err", 32'(rx_frame_err), 32'd0);
      check_value("rx_active", 32'(rx_active), 32'd0);
      check_value("rx_data", 32'(rx_data), 32'd0);

      for (int i = 0; i < 2 * N_LOOP; i++) begin
         if (i == N_LOOP) begin
            wait_idle();
            @(posedge clk);
            parity_en <= 1'b1; // second half with parity
         end
         rand_bits(WORD_WIDTH, r);
         send_word(r[WORD_WIDTH-1:0]);
      end

      wait_idle();
      @(posedge clk);
      loop_sel <= 1'b0;
      for (int i = 0; i < N_PAR; i++) begin
         rand_bits(WORD_WIDTH, r);
         exp_q.push_back({1'b0, 1'b1, r[WORD_WIDTH-1:0]});
         n_accepted++;
         send_frame(r[WORD_WIDTH-1:0], 1'b1, 1'b1);
      end

      wait_idle();
      @(posedge clk);
      parity_en <= 1'b0;
      for (int i = 0; i < N_STOP; i++) begin
         rand_bits(WORD_WIDTH, r);
         exp_q.push_back({1'b1, 1'b0, r[WORD_WIDTH-1:0]});
         send_frame(r[WORD_WIDTH-1:0], 1'b0, 1'b0);
      end

      wait_idle();
      @(posedge clk);
      loop_sel <= 1'b1;
      for (int i = 0; i < N_DROP; i++) begin
         rand_bits(WORD_WIDTH, r);
         send_word(r[WORD_WIDTH-1:0]);
         repeat (3) @(posedge clk);
         rand_bits(WORD_WIDTH, r);
         tx_start <= 1'b1; // dropped since the transmitter is busy
         tx_data  <= r[WORD_WIDTH-1:0];
         @(posedge clk);
         tx_start <= 1'b0;
      end

      wait_idle();
      repeat (2 * BIT_CLKS) @(posedge clk);
      check_value("received word count", 32'(n_received), 32'(n_accepted));
      if (exp_q.size() != 0)
         fail_run("expected frames never arrived at the receiver");
      else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

// File: uart_sva.sv
module uart_sva (
   input logic clk,
   input logic rst_n,
   input logic tx_start,
   input logic tx_busy,
   input logic txd,
   input logic rx_valid,
   input logic rx_frame_err,
   input logic rx_parity_err
);

   valid_vs_frame_err: assert property (@(posedge clk) disable iff (!rst_n)
      !(rx_valid && rx_frame_err))
      else $error("rx_valid and rx_frame_err high in the same cycle");

   start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_start && tx_busy) |=> $stable(txd))
      else $error("txd moved after a tx_start given while busy");

   idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
      !tx_busy |-> txd)
      else $error("txd low while the transmitter is idle");

   valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      rx_valid |=> !rx_valid)
      else $error("rx_valid longer than one cycle");

   frame_err_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      rx_frame_err |=> !rx_frame_err)
      else $error("rx_frame_err longer than one cycle");

   parity_err_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      rx_parity_err |=> !rx_parity_err)
      else $error("rx_parity_err longer than one cycle");

endmodule

bind uart_top uart_sva sva_inst (
   .clk           (clk),
   .rst_n         (rst_n),
   .tx_start      (tx_start),
   .tx_busy       (tx_busy),
   .txd           (txd),
   .rx_valid      (rx_valid),
   .rx_frame_err  (rx_frame_err),
   .rx_parity_err (rx_parity_err)
);

// File: tb_clk_gen.sv
module tb_clk_gen #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk; // free running

endmodule

// File: uart_top.sv
module uart_top #(
   parameter int WORD_WIDTH    = 8,
   parameter int OVERSAMPLING  = 16,
   parameter int CLKS_PER_TICK = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  rxd,
   input  logic                  parity_en,
   input  logic                  tx_start,
   input  logic [WORD_WIDTH-1:0] tx_data,
   output logic                  txd,
   output logic                  tx_busy,
   output logic [WORD_WIDTH-1:0] rx_data,
   output logic                  rx_valid,
   output logic                  rx_parity_err,
   output logic                  rx_frame_err,
   output logic                  rx_active
);

   logic                tick;
   logic [WORD_WIDTH:0] shift_data;
   logic                frame_done;
   logic                frame_err;

   uart_baud_gen #(
      .CLKS_PER_TICK(CLKS_PER_TICK)
   ) baud_gen_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .tick  (tick)
   );

   uart_rx_des #(
      .WORD_WIDTH   (WORD_WIDTH),
      .OVERSAMPLING (OVERSAMPLING)
   ) rx_des_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .tick       (tick),
      .rxd        (rxd),
      .parity_en  (parity_en),
      .shift_data (shift_data),
      .frame_done (frame_done),
      .frame_err  (frame_err),
      .rx_active  (rx_active)
   );

   uart_rx_check #(
      .WORD_WIDTH(WORD_WIDTH)
   ) rx_check_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .parity_en     (parity_en),
      .frame_done    (frame_done),
      .frame_err     (frame_err),
      .shift_data    (shift_data),
      .rx_data       (rx_data),
      .rx_valid      (rx_valid),
      .rx_parity_err (rx_parity_err),
      .rx_frame_err  (rx_frame_err)
   );

   uart_tx_ser #(
      .WORD_WIDTH   (WORD_WIDTH),
      .OVERSAMPLING (OVERSAMPLING)
   ) tx_ser_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .tick      (tick),
      .parity_en (parity_en),
      .tx_start  (tx_start),
      .tx_data   (tx_data),
      .txd       (txd),
      .tx_busy   (tx_busy)
   );

endmodule

// File: uart_tx_ser.sv
module uart_tx_ser import uart_pkg::*; #(
   parameter int WORD_WIDTH   = 8,
   parameter int OVERSAMPLING = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  tick,
   input  logic                  parity_en,
   input  logic                  tx_start,
   input  logic [WORD_WIDTH-1:0] tx_data,
   output logic                  txd,
   output logic                  tx_busy
);

   localparam int TW = $clog2(OVERSAMPLING);
   localparam int BW = $clog2(WORD_WIDTH + 1);
   localparam logic [TW-1:0] TICK_LAST = TW'(OVERSAMPLING - 1);

   tx_state_t state;

   logic [TW-1:0]         tick_ctr;
   logic [BW-1:0]         bit_ctr;
   logic [WORD_WIDTH-1:0] data_q;
   logic [WORD_WIDTH-1:0] data_next;
   logic                  par_q;
   logic                  accept;
   logic                  bit_end;

   assign accept    = tx_start && !tx_busy; // strobes while busy are dropped
   assign bit_end   = tick && (tick_ctr == '0);
   assign data_next = data_q >> 1;

   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= tx_data;
         par_q  <= even_parity(16'(tx_data));
      end else if (state == TX_DATA && bit_end) begin
         data_q <= data_next;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= TX_IDLE;
         tick_ctr <= '0;
         bit_ctr  <= '0;
         txd      <= 1'b1;
         tx_busy  <= 1'b0;
      end else begin
         if (tick && tick_ctr != '0)
            tick_ctr <= tick_ctr - 1'b1;
         case (state)
            TX_IDLE: begin
               if (accept) begin
                  state    <= TX_START;
                  txd      <= 1'b0; // start bit
                  tx_busy  <= 1'b1;
                  tick_ctr <= TICK_LAST;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  state    <= TX_DATA;
                  txd      <= data_q[0];
                  bit_ctr  <= '0;
                  tick_ctr <= TICK_LAST;
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  tick_ctr <= TICK_LAST;
                  if (bit_ctr == BW'(WORD_WIDTH - 1)) begin
                     state <= parity_en ? TX_PARITY : TX_STOP;
                     txd   <= parity_en ? par_q : 1'b1;
                  end else begin
                     bit_ctr <= bit_ctr + 1'b1;
                     txd     <= data_next[0];
                  end
               end
            end
            TX_PARITY: begin
               if (bit_end) begin
                  state    <= TX_STOP;
                  txd      <= 1'b1;
                  tick_ctr <= TICK_LAST;
               end
            end
            TX_STOP: begin
               if (bit_end) begin
                  state   <= TX_IDLE; // line stays high
                  tx_busy <= 1'b0;
               end
            end
            default: begin
               state   <= TX_IDLE;
               txd     <= 1'b1;
               tx_busy <= 1'b0;
            end
         endcase
      end
   end

endmodule

// File: uart_rx_check.sv
module uart_rx_check import uart_pkg::*; #(
   parameter int WORD_WIDTH = 8
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  parity_en,
   input  logic                  frame_done,
   input  logic                  frame_err,
   input  logic [WORD_WIDTH:0]   shift_data,
   output logic [WORD_WIDTH-1:0] rx_data,
   output logic                  rx_valid,
   output logic                  rx_parity_err,
   output logic                  rx_frame_err
);

   logic [WORD_WIDTH-1:0] word;
   logic                  parity_bit;
   logic                  parity_bad;

   // with parity the word ends one shift lower
   assign word       = parity_en ? shift_data[WORD_WIDTH-1:0] : shift_data[WORD_WIDTH:1];
   assign parity_bit = shift_data[WORD_WIDTH];

   // data plus parity bit must hold an even number of ones
   assign parity_bad = parity_en && (even_parity(16'(word)) != parity_bit);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_data       <= '0;
         rx_valid      <= 1'b0;
         rx_parity_err <= 1'b0;
         rx_frame_err  <= 1'b0;
      end else begin
         rx_valid      <= frame_done;
         rx_parity_err <= frame_done && parity_bad;
         rx_frame_err  <= frame_err;
         if (frame_done)
            rx_data <= word; // held on framing errors
      end
   end

endmodule

// File: uart_rx_des.sv
module uart_rx_des import uart_pkg::*; #(
   parameter int WORD_WIDTH   = 8,
   parameter int OVERSAMPLING = 16
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  tick,
   input  logic                  rxd,
   input  logic                  parity_en,
   output logic [WORD_WIDTH:0]   shift_data,
   output logic                  frame_done,
   output logic                  frame_err,
   output logic                  rx_active
);

   localparam int TW = $clog2(OVERSAMPLING);
   localparam int BW = $clog2(WORD_WIDTH + 1);
   localparam logic [TW-1:0] TICK_MID  = TW'(OVERSAMPLING / 2 - 1);
   localparam logic [TW-1:0] TICK_LAST = TW'(OVERSAMPLING - 1);

   rx_state_t state, state_nxt;

   logic          rxd_meta;
   logic          rxd_sync;
   logic [TW-1:0] tick_ctr, tick_nxt;
   logic [BW-1:0] bit_ctr, bit_nxt;
   logic [BW-1:0] last_bit;
   logic [WORD_WIDTH:0] shift_nxt;

   assign last_bit = parity_en ? BW'(WORD_WIDTH) : BW'(WORD_WIDTH - 1); // extra parity bit

   // two flop synchronizer on the idle high line
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= RX_IDLE;
         tick_ctr <= '0;
         bit_ctr  <= '0;
      end else begin
         state    <= state_nxt;
         tick_ctr <= tick_nxt;
         bit_ctr  <= bit_nxt;
      end
   end

   always_ff @(posedge clk) begin
      shift_data <= shift_nxt;
   end

   always_comb begin
      state_nxt  = state;
      tick_nxt   = tick_ctr;
      bit_nxt    = bit_ctr;
      shift_nxt  = shift_data;
      frame_done = 1'b0;
      frame_err  = 1'b0;

      case (state)
         RX_IDLE: begin
            if (!rxd_sync) begin
               state_nxt = RX_START;
               tick_nxt  = TICK_MID; // aim at middle of start bit
            end
         end
         RX_START: begin
            if (tick) begin
               if (tick_ctr == '0) begin
                  if (rxd_sync) begin
                     state_nxt = RX_IDLE; // glitch instead of a start bit
                  end else begin
                     state_nxt = RX_DATA;
                     tick_nxt  = TICK_LAST;
                     bit_nxt   = '0;
                  end
               end else begin
                  tick_nxt = tick_ctr - 1'b1;
               end
            end
         end
         RX_DATA: begin
            if (tick) begin
               if (tick_ctr == '0) begin
                  shift_nxt = {rxd_sync, shift_data[WORD_WIDTH:1]}; // lsb first
                  tick_nxt  = TICK_LAST;
                  if (bit_ctr == last_bit)
                     state_nxt = RX_STOP;
                  else
                     bit_nxt = bit_ctr + 1'b1;
               end else begin
                  tick_nxt = tick_ctr - 1'b1;
               end
            end
         end
         RX_STOP: begin
            if (tick) begin
               if (tick_ctr == '0) begin
                  state_nxt = RX_IDLE;
                  if (rxd_sync)
                     frame_done = 1'b1;
                  else
                     frame_err = 1'b1; // stop bit low
               end else begin
                  tick_nxt = tick_ctr - 1'b1;
               end
            end
         end
         default: state_nxt = RX_IDLE;
      endcase
   end

   assign rx_active = (state != RX_IDLE);

endmodule

// File: uart_baud_gen.sv
module uart_baud_gen #(
   parameter int CLKS_PER_TICK = 4
) (
   input  logic clk,
   input  logic rst_n,
   output logic tick
);

   localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
   localparam logic [CW-1:0] RELOAD = CW'(CLKS_PER_TICK - 1);

   logic [CW-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt  <= RELOAD;
         tick <= 1'b0;
      end else if (cnt == '0) begin
         cnt  <= RELOAD; // wrap
         tick <= 1'b1;
      end else begin
         cnt  <= cnt - 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

// File: uart_pkg.sv
package uart_pkg;

   // receiver FSM
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,
      RX_START = 2'd1,
      RX_DATA  = 2'd2,
      RX_STOP  = 2'd3
   } rx_state_t;

   // transmitter FSM
   typedef enum logic [2:0] {
      TX_IDLE   = 3'd0,
      TX_START  = 3'd1,
      TX_DATA   = 3'd2,
      TX_PARITY = 3'd3,
      TX_STOP   = 3'd4
   } tx_state_t;

   localparam int PARITY_MAX_WIDTH = 16;

   // even parity bit of a zero padded word
   function automatic logic even_parity(input logic [PARITY_MAX_WIDTH-1:0] word);
      logic p;
      p = ^word;
      return p;
   endfunction

endpackage
